//--- verilog/edu_pkg.sv
`default_nettype none

package edu_pkg;

    // ancilla grid
    localparam int NUM_AQROW = 4;
    localparam int NUM_AQCOL = 4;
    localparam int NUM_AQ = NUM_AQROW * NUM_AQCOL;

    // data qubits share the ancilla grid, index r * NUM_AQCOL + c
    localparam int NUM_DQ = NUM_AQ;

    // strobes per layer
    localparam int CODE_DIST = 3;

    // round counter must hold CODE_DIST-1
    localparam int ROUND_BW = 2;

    localparam int OPCODE_BW = 4;

    // controller opcodes
    localparam logic [OPCODE_BW-1:0] INVALID_OPCODE = 4'd0;
    localparam logic [OPCODE_BW-1:0] RUN_ESM_OPCODE = 4'd1;

    // logical measurements in x, y and z
    localparam logic [OPCODE_BW-1:0] LQM_X_OPCODE = 4'd2;
    localparam logic [OPCODE_BW-1:0] LQM_Y_OPCODE = 4'd3;
    localparam logic [OPCODE_BW-1:0] LQM_Z_OPCODE = 4'd4;

    // data qubits measured between layers
    localparam logic [OPCODE_BW-1:0] MEAS_INTMD_OPCODE = 4'd5;

endpackage

`default_nettype wire

//--- verilog/edu_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module edu_sequencer (
    input  logic                                 clk,
    input  logic                                 rst,
    input  logic                                 tcu_valid,
    input  logic [edu_pkg::OPCODE_BW-1:0]        tcu_opcode,
    input  logic                                 dqmeas_valid,
    input  logic [edu_pkg::NUM_DQ-1:0]           dqmeas_array,
    input  logic                                 aqmeas_valid,
    output logic                                 first_round,
    output logic [edu_pkg::NUM_AQ-1:0]           flip_array,
    output logic                                 report_valid,
    output logic                                 report_pf
);

    logic [edu_pkg::OPCODE_BW-1:0] opcode_reg;
    logic [edu_pkg::ROUND_BW-1:0]  round_cnt;
    logic                          pf_opcode;
    logic                          intmd_meas;

    // held opcode, esm runs keep the previous one
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            opcode_reg <= edu_pkg::INVALID_OPCODE;
        end
        else if (tcu_valid && (tcu_opcode != edu_pkg::RUN_ESM_OPCODE))
        begin
            opcode_reg <= tcu_opcode;
        end
    end

    // position within the layer
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            round_cnt <= '0;
        end
        else if (aqmeas_valid)
        begin
            if (round_cnt == edu_pkg::ROUND_BW'(edu_pkg::CODE_DIST - 1))
            begin
                round_cnt <= '0;
            end
            else
            begin
                round_cnt <= round_cnt + 1'b1;
            end
        end
    end

    assign first_round = (round_cnt == '0);

    assign pf_opcode = (opcode_reg == edu_pkg::LQM_X_OPCODE) ||
                       (opcode_reg == edu_pkg::LQM_Y_OPCODE) ||
                       (opcode_reg == edu_pkg::LQM_Z_OPCODE) ||
                       (opcode_reg == edu_pkg::MEAS_INTMD_OPCODE);

    assign intmd_meas = dqmeas_valid && (opcode_reg == edu_pkg::MEAS_INTMD_OPCODE);

    // each data qubit toggles the ancillas to its upper left
    always_comb
    begin
        flip_array = '0;
        if (intmd_meas)
        begin
            for (int r = 0; r < edu_pkg::NUM_AQROW; r++)
            begin
                for (int c = 0; c < edu_pkg::NUM_AQCOL; c++)
                begin
                    if (r > 0 && c > 0)
                    begin
                        flip_array[(r-1)*edu_pkg::NUM_AQCOL + c-1] =
                            flip_array[(r-1)*edu_pkg::NUM_AQCOL + c-1] ^
                            dqmeas_array[r*edu_pkg::NUM_AQCOL + c];
                    end
                    if (r > 0)
                    begin
                        flip_array[(r-1)*edu_pkg::NUM_AQCOL + c] =
                            flip_array[(r-1)*edu_pkg::NUM_AQCOL + c] ^
                            dqmeas_array[r*edu_pkg::NUM_AQCOL + c];
                    end
                    if (c > 0)
                    begin
                        flip_array[r*edu_pkg::NUM_AQCOL + c-1] =
                            flip_array[r*edu_pkg::NUM_AQCOL + c-1] ^
                            dqmeas_array[r*edu_pkg::NUM_AQCOL + c];
                    end
                    flip_array[r*edu_pkg::NUM_AQCOL + c] =
                        flip_array[r*edu_pkg::NUM_AQCOL + c] ^
                        dqmeas_array[r*edu_pkg::NUM_AQCOL + c];
                end
            end
        end
    end

    // report strobe lines up with the cell eigen registers
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            report_valid <= 1'b0;
            report_pf    <= 1'b0;
        end
        else
        begin
            report_valid <= aqmeas_valid;
            report_pf    <= aqmeas_valid && pf_opcode;
        end
    end

    round_in_range: assert property (@(posedge clk) disable iff (rst)
        round_cnt < edu_pkg::ROUND_BW'(edu_pkg::CODE_DIST));

endmodule

`default_nettype wire

//--- verilog/edu_cell.sv
`timescale 1ns/1ns
`default_nettype none

module edu_cell (
    input  logic clk,
    input  logic rst,
    input  logic aqmeas_valid,
    input  logic aqmeas,
    input  logic first_round,
    input  logic flip_in,
    output logic eigen
);

    // last ancilla measurement of this cell
    logic reference;
    // data qubit flips since that measurement
    logic pending;
    logic eff_flip;

    // a data strobe in the same cycle still counts
    assign eff_flip = pending ^ flip_in;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            reference <= 1'b0;
            pending   <= 1'b0;
        end
        else if (aqmeas_valid)
        begin
            reference <= aqmeas;
            pending   <= 1'b0;
        end
        else
        begin
            pending <= eff_flip;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            eigen <= 1'b0;
        end
        else if (aqmeas_valid)
        begin
            // first strobe of a layer only sets the reference
            if (first_round)
            begin
                eigen <= 1'b0;
            end
            else
            begin
                eigen <= aqmeas ^ reference ^ eff_flip;
            end
        end
    end

    aqmeas_known: assert property (@(posedge clk) disable iff (rst)
        aqmeas_valid |-> !$isunknown(aqmeas));

endmodule

`default_nettype wire

//--- verilog/edu_collector.sv
`timescale 1ns/1ns
`default_nettype none

module edu_collector (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       report_valid,
    input  logic                       report_pf,
    input  logic [edu_pkg::NUM_AQ-1:0] eigen_cells,
    output logic [edu_pkg::NUM_AQ-1:0] eigen_array,
    output logic                       edu_valid,
    output logic                       pfflag
);

    // flips held until the next report
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            eigen_array <= '0;
        end
        else if (report_valid)
        begin
            eigen_array <= eigen_cells;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            edu_valid <= 1'b0;
            pfflag    <= 1'b0;
        end
        else
        begin
            edu_valid <= report_valid;
            pfflag    <= report_pf;
        end
    end

    pf_needs_valid: assert property (@(posedge clk) disable iff (rst)
        pfflag |-> edu_valid);

endmodule

`default_nettype wire

//--- verilog/edu_top.sv
`timescale 1ns/1ns
`default_nettype none

module edu_top (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          aqmeas_valid,
    input  logic [edu_pkg::NUM_AQ-1:0]    aqmeas_array,
    input  logic                          dqmeas_valid,
    input  logic [edu_pkg::NUM_DQ-1:0]    dqmeas_array,
    input  logic                          tcu_valid,
    input  logic [edu_pkg::OPCODE_BW-1:0] tcu_opcode,
    output logic [edu_pkg::NUM_AQ-1:0]    eigen_array,
    output logic                          edu_valid,
    output logic                          pfflag
);

    logic                       first_round;
    logic [edu_pkg::NUM_AQ-1:0] flip_array;
    logic                       report_valid;
    logic                       report_pf;
    logic [edu_pkg::NUM_AQ-1:0] eigen_cells;

    edu_sequencer i_sequencer (
        .clk          (clk),
        .rst          (rst),
        .tcu_valid    (tcu_valid),
        .tcu_opcode   (tcu_opcode),
        .dqmeas_valid (dqmeas_valid),
        .dqmeas_array (dqmeas_array),
        .aqmeas_valid (aqmeas_valid),
        .first_round  (first_round),
        .flip_array   (flip_array),
        .report_valid (report_valid),
        .report_pf    (report_pf)
    );

    // one cell per ancilla, row major
    for (genvar r = 0; r < edu_pkg::NUM_AQROW; r++)
    begin : gen_row
        for (genvar c = 0; c < edu_pkg::NUM_AQCOL; c++)
        begin : gen_col
            edu_cell i_cell (
                .clk          (clk),
                .rst          (rst),
                .aqmeas_valid (aqmeas_valid),
                .aqmeas       (aqmeas_array[r*edu_pkg::NUM_AQCOL + c]),
                .first_round  (first_round),
                .flip_in      (flip_array[r*edu_pkg::NUM_AQCOL + c]),
                .eigen        (eigen_cells[r*edu_pkg::NUM_AQCOL + c])
            );
        end
    end

    edu_collector i_collector (
        .clk          (clk),
        .rst          (rst),
        .report_valid (report_valid),
        .report_pf    (report_pf),
        .eigen_cells  (eigen_cells),
        .eigen_array  (eigen_array),
        .edu_valid    (edu_valid),
        .pfflag       (pfflag)
    );

endmodule

`default_nettype wire

//--- verification/edu_tb.sv
`timescale 1ns/1ns
`default_nettype none

module edu_tb;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 3;
    localparam int NUM_CYCLES   = 2000;
    // run length plus some slack for reset and drain
    localparam int WATCHDOG_NS  = (NUM_CYCLES + RESET_CYCLES + 20) * CLK_PERIOD;

    logic                          clk;
    logic                          rst;
    logic                          aqmeas_valid;
    logic [edu_pkg::NUM_AQ-1:0]    aqmeas_array;
    logic                          dqmeas_valid;
    logic [edu_pkg::NUM_DQ-1:0]    dqmeas_array;
    logic                          tcu_valid;
    logic [edu_pkg::OPCODE_BW-1:0] tcu_opcode;
    logic [edu_pkg::NUM_AQ-1:0]    eigen_array;
    logic                          edu_valid;
    logic                          pfflag;

    int seed = 32'he145_3081;
    int cyc = 0;
    bit checking = 1'b0;

    // reference model state
    logic [edu_pkg::NUM_AQ-1:0]    ref_m = '0;
    logic [edu_pkg::NUM_AQ-1:0]    pend_m = '0;
    logic [edu_pkg::OPCODE_BW-1:0] opcode_m = edu_pkg::INVALID_OPCODE;
    int                            round_m = 0;
    logic [edu_pkg::NUM_AQ-1:0]    last_eigen = '0;

    // expected reports, oldest first
    int                            due_q[$];
    logic [edu_pkg::NUM_AQ-1:0]    eigen_q[$];
    logic                          pf_q[$];

    edu_top i_dut (
        .clk          (clk),
        .rst          (rst),
        .aqmeas_valid (aqmeas_valid),
        .aqmeas_array (aqmeas_array),
        .dqmeas_valid (dqmeas_valid),
        .dqmeas_array (dqmeas_array),
        .tcu_valid    (tcu_valid),
        .tcu_opcode   (tcu_opcode),
        .eigen_array  (eigen_array),
        .edu_valid    (edu_valid),
        .pfflag       (pfflag)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // an ancilla sees the data qubits at its own position, right, below and below right
    function automatic logic [edu_pkg::NUM_AQ-1:0] ancilla_flips(
        input logic [edu_pkg::NUM_DQ-1:0] dq
    );
        logic [edu_pkg::NUM_AQ-1:0] f;
        f = '0;
        for (int ar = 0; ar < edu_pkg::NUM_AQROW; ar++)
        begin
            for (int ac = 0; ac < edu_pkg::NUM_AQCOL; ac++)
            begin
                for (int dr = 0; dr < 2; dr++)
                begin
                    for (int dc = 0; dc < 2; dc++)
                    begin
                        if ((ar + dr < edu_pkg::NUM_AQROW) && (ac + dc < edu_pkg::NUM_AQCOL))
                        begin
                            f[ar*edu_pkg::NUM_AQCOL + ac] = f[ar*edu_pkg::NUM_AQCOL + ac] ^
                                dq[(ar + dr)*edu_pkg::NUM_AQCOL + ac + dc];
                        end
                    end
                end
            end
        end
        return f;
    endfunction

    function automatic logic posts_flag(input logic [edu_pkg::OPCODE_BW-1:0] op);
        return (op == edu_pkg::LQM_X_OPCODE) || (op == edu_pkg::LQM_Y_OPCODE) ||
               (op == edu_pkg::LQM_Z_OPCODE) || (op == edu_pkg::MEAS_INTMD_OPCODE);
    endfunction

    task automatic check_bit(input logic actual, input logic expected, input string what);
        assert (actual === expected)
        else
        begin
            $display("Mismatch at %0t ns: %s is %b, expected %b", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    task automatic check_vec(
        input logic [edu_pkg::NUM_AQ-1:0] actual,
        input logic [edu_pkg::NUM_AQ-1:0] expected,
        input string what
    );
        assert (actual === expected)
        else
        begin
            $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
            $display("Test failed");
            $fatal(1);
        end
    endtask

    // apply one clock edge worth of inputs to the model
    task automatic model_step();
        logic [edu_pkg::NUM_AQ-1:0] flips;
        logic [edu_pkg::NUM_AQ-1:0] eff;
        logic [edu_pkg::NUM_AQ-1:0] eig;
        flips = '0;
        if (dqmeas_valid && (opcode_m == edu_pkg::MEAS_INTMD_OPCODE))
        begin
            flips = ancilla_flips(dqmeas_array);
        end
        eff = pend_m ^ flips;
        if (aqmeas_valid)
        begin
            if (round_m == 0)
            begin
                eig = '0;
            end
            else
            begin
                eig = aqmeas_array ^ ref_m ^ eff;
            end
            due_q.push_back(cyc + 1);
            eigen_q.push_back(eig);
            pf_q.push_back(posts_flag(opcode_m));
            ref_m = aqmeas_array;
            pend_m = '0;
            round_m = (round_m == edu_pkg::CODE_DIST - 1) ? 0 : round_m + 1;
        end
        else
        begin
            pend_m = eff;
        end
        if (tcu_valid && (tcu_opcode != edu_pkg::RUN_ESM_OPCODE))
        begin
            opcode_m = tcu_opcode;
        end
    endtask

    task automatic drive_inputs();
        int rnd;
        rnd = $random(seed);
        // quiet tail so the last reports drain
        if (cyc > NUM_CYCLES - 4)
        begin
            aqmeas_valid <= 1'b0;
            dqmeas_valid <= 1'b0;
            tcu_valid    <= 1'b0;
        end
        else
        begin
            aqmeas_valid <= (rnd[3:0] < 4'd7);
            dqmeas_valid <= (rnd[7:4] < 4'd6);
            tcu_valid    <= (rnd[10:8] == 3'd0);
            tcu_opcode   <= rnd[11] ? edu_pkg::MEAS_INTMD_OPCODE : rnd[15:12];
        end
        rnd = $random(seed);
        aqmeas_array <= rnd[edu_pkg::NUM_AQ-1:0];
        rnd = $random(seed);
        dqmeas_array <= rnd[edu_pkg::NUM_DQ-1:0];
    endtask

    // outputs have settled by the falling edge
    always @(negedge clk)
    begin
        if (checking)
        begin
            if ((due_q.size() > 0) && (due_q[0] == cyc))
            begin
                check_bit(edu_valid, 1'b1, "edu_valid");
                check_bit(pfflag, pf_q[0], "pfflag");
                check_vec(eigen_array, eigen_q[0], "eigen_array");
                last_eigen = eigen_q[0];
                void'(due_q.pop_front());
                void'(eigen_q.pop_front());
                void'(pf_q.pop_front());
            end
            else
            begin
                check_bit(edu_valid, 1'b0, "edu_valid");
                check_bit(pfflag, 1'b0, "pfflag");
                check_vec(eigen_array, last_eigen, "held eigen_array");
            end
        end
    end

    initial
    begin
        rst          = 1'b1;
        aqmeas_valid = 1'b0;
        aqmeas_array = '0;
        dqmeas_valid = 1'b0;
        dqmeas_array = '0;
        tcu_valid    = 1'b0;
        tcu_opcode   = edu_pkg::INVALID_OPCODE;
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;
        checking = 1'b1;
        repeat (NUM_CYCLES)
        begin
            @(posedge clk);
            cyc++;
            model_step();
            drive_inputs();
        end
        repeat (2) @(negedge clk);
        $display("Test completed successfully");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns", WATCHDOG_NS);
        $display("Test failed");
        $fatal(1);
    end

endmodule

`default_nettype wire

//--- files.f
verilog/edu_pkg.sv
verilog/edu_sequencer.sv
verilog/edu_cell.sv
verilog/edu_collector.sv
verilog/edu_top.sv
verification/edu_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the EDU testbench with Verilator.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir

verilator --binary --timing --assert \
    --top-module edu_tb \
    -f files.f \
    -o Vedu_tb

# the simulator exits non-zero on $fatal, so keep its output for the search
sim_out=$(./obj_dir/Vedu_tb 2>&1 || true)
echo "$sim_out"

if echo "$sim_out" | grep -q "Test completed successfully"; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
